// ==== flist.f ====
+incdir+logic
logic/dd2_pkg.sv
logic/dd2_dwnld.sv
logic/dd2_rom_slot.sv
logic/dd2_sdram_arb.sv
logic/dd2_rom_top.sv
test/dd2_rom_props.sv
test/dd2_rom_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the ROM-side testbench with Verilator
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 --top-module dd2_rom_tb -f flist.f

./obj_dir/Vdd2_rom_tb 2>&1 | tee sim.log || true

if grep -q 'All tests passed!' sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi

// ==== test/dd2_rom_tb.sv ====
/*
 * Testbench for dd2_rom_top. The SDRAM model answers writes and reads after
 * 1 to 4 random cycles; each read half is its word address XOR 0x5a5a.
 */
`timescale 1ns/1ns
`include "dd2_params.svh"

module dd2_rom_tb;
    import dd2_pkg::*;

    typedef struct packed {
        logic [21:0] addr;
        logic [7:0]  data;
        logic [21:0] exp_addr;
        logic [1:0]  exp_mask;
        logic        prom;
    } dl_entry_t;

    typedef struct packed {
        logic [1:0]  slot;      // 0 main, 1 snd, 2 obj
        logic [21:0] addr;
        logic        hit;       // Same cached word as the slot's last read
    } rd_entry_t;

    localparam int DL_N = 14;
    localparam int RD_N = 12;
    localparam int WATCHDOG_CYCLES = (DL_N + RD_N + 3) * 40;

    localparam dl_entry_t DL_TAB [DL_N] = '{
        '{22'h00_0000, 8'h11, 22'h00_0000, 2'b10, 1'b0},
        '{22'h00_0001, 8'h22, 22'h00_0000, 2'b01, 1'b0},
        '{22'h02_8005, 8'h33, 22'h01_4002, 2'b01, 1'b0},
        '{22'h08_fffe, 8'h44, 22'h04_7fff, 2'b10, 1'b0},
        '{22'h09_0000, 8'h55, 22'h06_0000, 2'b10, 1'b0},   // Scroll ZW start
        '{22'h0b_0000, 8'h66, 22'h06_0000, 2'b01, 1'b0},   // Scroll XY, same word
        '{22'h09_0123, 8'h77, 22'h06_0123, 2'b10, 1'b0},
        '{22'h0b_0123, 8'h88, 22'h06_0123, 2'b01, 1'b0},
        '{22'h0a_ffff, 8'h99, 22'h07_ffff, 2'b10, 1'b0},
        '{22'h0d_0000, 8'haa, 22'h08_0000, 2'b10, 1'b0},   // Object WZ
        '{22'h13_0000, 8'hbb, 22'h08_0000, 2'b01, 1'b0},
        '{22'h12_ffff, 8'hcc, 22'h0d_ffff, 2'b10, 1'b0},
        '{22'h19_0000, 8'hdd, 22'h00_0000, 2'b11, 1'b1},   // PROM
        '{22'h19_01a7, 8'hee, 22'h00_00a7, 2'b11, 1'b1}
    };

    localparam rd_entry_t RD_TAB [RD_N] = '{
        '{2'd0, 22'h00_0123, 1'b0}, '{2'd0, 22'h00_0121, 1'b1}, '{2'd0, 22'h00_0122, 1'b1},
        '{2'd1, 22'h00_0456, 1'b0}, '{2'd1, 22'h00_0457, 1'b1}, '{2'd2, 22'h01_2345, 1'b0},
        '{2'd2, 22'h01_2344, 1'b1}, '{2'd0, 22'h03_ffff, 1'b0}, '{2'd1, 22'h00_7ffc, 1'b0},
        '{2'd2, 22'h07_ffff, 1'b0}, '{2'd0, 22'h00_0124, 1'b0}, '{2'd2, 22'h00_0001, 1'b0}
    };

    // Three misses at once, listed in expected service order
    localparam rd_entry_t PRIO_TAB [3] = '{
        '{2'd0, 22'h02_a55a, 1'b0}, '{2'd1, 22'h00_1001, 1'b0}, '{2'd2, 22'h04_0002, 1'b0}
    };

    logic                     clk = 1'b0;
    logic                     rst, downloading, ioctl_wr, sdram_ack, data_rdy;
    logic [`DD2_SDRAM_AW-1:0] ioctl_addr, prog_addr, sdram_addr;
    logic [7:0]               ioctl_data, prog_data, main_data, snd_data;
    logic [1:0]               prog_mask;
    logic                     prog_we, prom_we, sdram_req, refresh_en, rst_game;
    rom_word_t                data_read;
    logic                     main_cs, snd_cs, obj_cs, main_ok, snd_ok, obj_ok;
    logic [`DD2_MAIN_AW-1:0]  main_addr;
    logic [`DD2_SND_AW-1:0]   snd_addr;
    logic [`DD2_OBJ_AW-1:0]   obj_addr;
    logic [15:0]              obj_data;
    logic [21:0]              served [$];   // Word addresses read, in order
    int                       exp_reads = 0;

    dd2_rom_top i_dd2_rom_top(.*);

    always #10 clk = ~clk;

    task automatic stop_run(input string what);
        $display("%s", what);
        $display("Test failures found");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_cmd(input logic [21:0] exp_addr, input logic [7:0] exp_data,
                             input logic [1:0] exp_mask, input logic exp_prom);
        if (prog_we !== !exp_prom || prom_we !== exp_prom)
            stop_run($sformatf("[FAIL] prog_we/prom_we got %h/%h expected %h/%h",
                               prog_we, prom_we, !exp_prom, exp_prom));
        if (prog_addr !== exp_addr)
            stop_run($sformatf("[FAIL] prog_addr got %h expected %h", prog_addr, exp_addr));
        if (prog_data !== exp_data)
            stop_run($sformatf("[FAIL] prog_data got %h expected %h", prog_data, exp_data));
        if (!exp_prom && prog_mask !== exp_mask)
            stop_run($sformatf("[FAIL] prog_mask got %h expected %h", prog_mask, exp_mask));
    endtask

    task automatic check_byte(input string name, input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp)
            stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp));
    endtask

    task automatic check_half(input string name, input logic [15:0] got,
                              input rom_word_t exp_word, input logic sel);
        if (got !== exp_word.h[sel])
            stop_run($sformatf("[FAIL] %s got %h expected %h", name, got, exp_word.h[sel]));
    endtask

    // SDRAM contents as seen by one 32-bit read at word n
    function automatic rom_word_t sdram_word(input logic [21:0] n);
        rom_word_t   w;
        logic [21:0] n1;
        n1     = n + 22'd1;
        w.h[0] = n[15:0] ^ 16'h5a5a;
        w.h[1] = n1[15:0] ^ 16'h5a5a;
        return w;
    endfunction

    function automatic logic [21:0] fetch_addr(input logic [1:0] slot, input logic [21:0] a);
        case (slot)
            2'd0:    return (a >> 1) & ~22'd1;
            2'd1:    return (`DD2_SND_ADDR >> 1) + ((a >> 1) & ~22'd1);
            default: return `DD2_OBJ_SDRAM + (a & ~22'd1);
        endcase
    endfunction

    function automatic logic slot_ok(input logic [1:0] slot);
        case (slot)
            2'd0:    return main_ok;
            2'd1:    return snd_ok;
            default: return obj_ok;
        endcase
    endfunction

    task automatic drive_slot(input rd_entry_t e);
        case (e.slot)
            2'd0: begin
                main_cs   <= 1'b1;
                main_addr <= e.addr[`DD2_MAIN_AW-1:0];
            end
            2'd1: begin
                snd_cs   <= 1'b1;
                snd_addr <= e.addr[`DD2_SND_AW-1:0];
            end
            default: begin
                obj_cs   <= 1'b1;
                obj_addr <= e.addr[`DD2_OBJ_AW-1:0];
            end
        endcase
    endtask

    task automatic check_read_data(input rd_entry_t e);
        rom_word_t w;
        w = sdram_word(fetch_addr(e.slot, e.addr));
        case (e.slot)
            2'd0:    check_byte("main_data", main_data, w.b[e.addr[1:0]]);
            2'd1:    check_byte("snd_data", snd_data, w.b[e.addr[1:0]]);
            default: check_half("obj_data", obj_data, w, e.addr[0]);
        endcase
    endtask

    task automatic read_slot(input rd_entry_t e);
        int          waited;
        logic [21:0] n;
        n      = fetch_addr(e.slot, e.addr);
        waited = 0;
        @(posedge clk);
        drive_slot(e);
        do begin
            @(posedge clk);
            waited++;
        end while (!slot_ok(e.slot));
        if (!e.hit) begin
            exp_reads++;
        end else if (waited != 1) begin
            stop_run($sformatf("Slot %0d address %h should hit the cache but ok took %0d cycles",
                               e.slot, e.addr, waited));
        end
        if (served.size() != exp_reads)
            stop_run($sformatf("Expected %0d SDRAM reads so far but saw %0d",
                               exp_reads, served.size()));
        if (!e.hit && served[exp_reads-1] !== n)
            stop_run($sformatf("[FAIL] sdram_addr got %h expected %h", served[exp_reads-1], n));
        check_read_data(e);
    endtask

    // SDRAM model, acks writes and reads
    initial begin
        int unsigned wait_cycles;
        logic [21:0] rd_addr;
        void'($urandom(32'h1afa_6e47));
        sdram_ack <= 1'b0;
        data_rdy  <= 1'b0;
        data_read <= '0;
        forever begin
            @(posedge clk);
            if (prog_we || sdram_req) begin
                rd_addr     = sdram_addr;
                wait_cycles = 1 + ($urandom % 4);
                if (!prog_we)
                    served.push_back(rd_addr);
                repeat (wait_cycles - 1) @(posedge clk);
                sdram_ack <= 1'b1;
                @(posedge clk);
                sdram_ack <= 1'b0;
                if (!prog_we) begin
                    wait_cycles = 1 + ($urandom % 4);
                    repeat (wait_cycles - 1) @(posedge clk);
                    data_rdy  <= 1'b1;
                    data_read <= sdram_word(rd_addr);
                    @(posedge clk);
                    data_rdy  <= 1'b0;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (downloading && sdram_req)
            stop_run("sdram_req was raised while downloading");
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Timeout: DUT did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("Test failures found");
        $fatal(1, "watchdog expired");
    end

    initial begin
        rst         <= 1'b1;
        downloading <= 1'b1;
        ioctl_wr    <= 1'b0;
        ioctl_addr  <= '0;
        ioctl_data  <= '0;
        main_cs     <= 1'b1;    // Miss held off until download ends
        main_addr   <= RD_TAB[0].addr[`DD2_MAIN_AW-1:0];
        snd_cs      <= 1'b0;
        snd_addr    <= '0;
        obj_cs      <= 1'b0;
        obj_addr    <= '0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;

        for (int i = 0; i < DL_N; i++) begin
            @(posedge clk);
            ioctl_addr <= DL_TAB[i].addr;
            ioctl_data <= DL_TAB[i].data;
            ioctl_wr   <= 1'b1;
            @(posedge clk);
            ioctl_wr <= 1'b0;
            @(posedge clk);
            check_cmd(DL_TAB[i].exp_addr, DL_TAB[i].data, DL_TAB[i].exp_mask, DL_TAB[i].prom);
            if (rst_game !== 1'b1 || refresh_en !== 1'b1)
                stop_run("rst_game or refresh_en went low during download");
            while (prog_we) @(posedge clk);
        end

        @(posedge clk);
        downloading <= 1'b0;
        for (int k = 0; k < 3; k++) begin
            @(posedge clk);
            if (i_dd2_rom_top.rom_ready !== (k != 0))
                stop_run($sformatf("rom_ready wrong %0d cycles after download end", k + 1));
            if (rst_game !== 1'b1)
                stop_run("rst_game fell too early after download end");
        end
        @(posedge clk);
        if (rst_game !== 1'b0)
            stop_run("rst_game still high three cycles after download end");

        for (int i = 0; i < RD_N; i++) begin
            read_slot(RD_TAB[i]);
        end

        // All three slots miss on the same edge
        @(posedge clk);
        for (int k = 0; k < 3; k++) begin
            drive_slot(PRIO_TAB[k]);
        end
        do begin
            @(posedge clk);
        end while (!(main_ok && snd_ok && obj_ok));
        if (served.size() != exp_reads + 3)
            stop_run("Simultaneous misses did not give exactly three SDRAM reads");
        for (int k = 0; k < 3; k++) begin
            if (served[exp_reads+k] !== fetch_addr(PRIO_TAB[k].slot, PRIO_TAB[k].addr))
                stop_run($sformatf("[FAIL] sdram_addr got %h expected %h", served[exp_reads+k],
                                   fetch_addr(PRIO_TAB[k].slot, PRIO_TAB[k].addr)));
            check_read_data(PRIO_TAB[k]);
        end

        $display("All tests passed!");
        $finish;
    end

endmodule

// ==== test/dd2_rom_props.sv ====
/*
 * Handshake checks bound into dd2_rom_top, idle while rst is high.
 * Only the read side of sdram_ack is covered here.
 */
`timescale 1ns/1ns

module dd2_rom_props(
    input logic clk,
    input logic rst,
    input logic downloading,
    input logic sdram_req,
    input logic sdram_ack,
    input logic prom_we
);

    // Read request held until the controller takes it
    req_held: assert property (@(posedge clk) disable iff (rst)
        sdram_req && !sdram_ack |=> sdram_req)
        else $error("sdram_req dropped before sdram_ack");

    prom_pulse: assert property (@(posedge clk) disable iff (rst)
        prom_we |=> !prom_we)
        else $error("prom_we lasted more than one cycle");

    // No new read starts during download
    no_req_in_dwnld: assert property (@(posedge clk) disable iff (rst)
        downloading && !sdram_req |=> !sdram_req)
        else $error("sdram_req rose while downloading");

endmodule

bind dd2_rom_top dd2_rom_props i_props(
    .clk         ( clk         ),
    .rst         ( rst         ),
    .downloading ( downloading ),
    .sdram_req   ( sdram_req   ),
    .sdram_ack   ( sdram_ack   ),
    .prom_we     ( prom_we     )
);

// ==== logic/dd2_rom_top.sv ====
/*
 * ROM side of the board: download mapper, three cached read slots and the
 * SDRAM arbiter. rst_game releases three cycles after downloading falls.
 * PROM data is not stored here, only prom_we leaves the block.
 */
`timescale 1ns/1ns
`include "dd2_params.svh"

module dd2_rom_top(
    input  logic                     clk,
    input  logic                     rst,
    // Loader
    input  logic                     downloading,
    input  logic [`DD2_SDRAM_AW-1:0] ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    // SDRAM writes
    output logic [`DD2_SDRAM_AW-1:0] prog_addr,
    output logic [7:0]               prog_data,
    output logic [1:0]               prog_mask,
    output logic                     prog_we,
    output logic                     prom_we,
    // SDRAM reads
    output logic                     sdram_req,
    output logic [`DD2_SDRAM_AW-1:0] sdram_addr,
    input  logic                     sdram_ack,
    input  logic                     data_rdy,
    input  logic [31:0]              data_read,
    output logic                     refresh_en,
    // Game
    output logic                     rst_game,
    input  logic                     main_cs,
    input  logic [`DD2_MAIN_AW-1:0]  main_addr,
    output logic [7:0]               main_data,
    output logic                     main_ok,
    input  logic                     snd_cs,
    input  logic [`DD2_SND_AW-1:0]   snd_addr,
    output logic [7:0]               snd_data,
    output logic                     snd_ok,
    input  logic                     obj_cs,
    input  logic [`DD2_OBJ_AW-1:0]   obj_addr,
    output logic [15:0]              obj_data,
    output logic                     obj_ok
);
    import dd2_pkg::*;

    rom_word_t                rd_word;
    logic                     rom_ready;
    logic                     rst_aux;
    logic                     main_req, snd_req, obj_req;
    logic                     main_done, snd_done, obj_done;
    logic [`DD2_SDRAM_AW-1:0] main_req_addr, snd_req_addr, obj_req_addr;

    always_ff @(posedge clk) begin
        if (rst || downloading) rom_ready <= 1'b0;
        else                    rom_ready <= 1'b1;
    end

    // Two-stage release after the ROMs are in
    always_ff @(posedge clk) begin
        if (rst || !rom_ready) begin
            rst_game <= 1'b1;
            rst_aux  <= 1'b1;
        end else begin
            rst_game <= rst_aux;
            rst_aux  <= downloading;
        end
    end

    dd2_dwnld u_dwnld(
        .clk         ( clk         ),
        .rst         ( rst         ),
        .downloading ( downloading ),
        .ioctl_addr  ( ioctl_addr  ),
        .ioctl_data  ( ioctl_data  ),
        .ioctl_wr    ( ioctl_wr    ),
        .sdram_ack   ( sdram_ack   ),
        .prog_addr   ( prog_addr   ),
        .prog_data   ( prog_data   ),
        .prog_mask   ( prog_mask   ),
        .prog_we     ( prog_we     ),
        .prom_we     ( prom_we     )
    );

    dd2_rom_slot #(.AW(`DD2_MAIN_AW), .DW(8), .OFFSET(22'd0)) u_main(
        .clk(clk), .rst(rst), .cs(main_cs), .addr(main_addr), .done(main_done),
        .rdata(rd_word), .ok(main_ok), .data(main_data), .req(main_req),
        .req_addr(main_req_addr)
    );

    // Sound program sits right after main, as words
    dd2_rom_slot #(.AW(`DD2_SND_AW), .DW(8), .OFFSET(`DD2_SND_ADDR >> 1)) u_snd(
        .clk(clk), .rst(rst), .cs(snd_cs), .addr(snd_addr), .done(snd_done),
        .rdata(rd_word), .ok(snd_ok), .data(snd_data), .req(snd_req),
        .req_addr(snd_req_addr)
    );

    dd2_rom_slot #(.AW(`DD2_OBJ_AW), .DW(16), .OFFSET(`DD2_OBJ_SDRAM)) u_obj(
        .clk(clk), .rst(rst), .cs(obj_cs), .addr(obj_addr), .done(obj_done),
        .rdata(rd_word), .ok(obj_ok), .data(obj_data), .req(obj_req),
        .req_addr(obj_req_addr)
    );

    dd2_sdram_arb u_arb(
        .clk         ( clk           ),
        .rst         ( rst           ),
        .downloading ( downloading   ),
        .main_req    ( main_req      ),
        .snd_req     ( snd_req       ),
        .obj_req     ( obj_req       ),
        .main_addr   ( main_req_addr ),
        .snd_addr    ( snd_req_addr  ),
        .obj_addr    ( obj_req_addr  ),
        .sdram_ack   ( sdram_ack     ),
        .data_rdy    ( data_rdy      ),
        .data_read   ( data_read     ),
        .sdram_req   ( sdram_req     ),
        .sdram_addr  ( sdram_addr    ),
        .refresh_en  ( refresh_en    ),
        .main_done   ( main_done     ),
        .snd_done    ( snd_done      ),
        .obj_done    ( obj_done      ),
        .rdata       ( rd_word       )
    );

endmodule

// ==== logic/dd2_sdram_arb.sv ====
/*
 * Fixed priority: main, then snd, then obj. One read in flight at a time.
 * No new read starts while downloading. done and rdata are valid in the
 * data_rdy cycle so the slot fills its cache on that edge.
 */
`timescale 1ns/1ns

module dd2_sdram_arb(
    input  logic               clk,
    input  logic               rst,
    input  logic               downloading,
    input  logic               main_req,
    input  logic               snd_req,
    input  logic               obj_req,
    input  logic [21:0]        main_addr,
    input  logic [21:0]        snd_addr,
    input  logic [21:0]        obj_addr,
    input  logic               sdram_ack,
    input  logic               data_rdy,
    input  dd2_pkg::rom_word_t data_read,
    output logic               sdram_req,
    output logic [21:0]        sdram_addr,
    output logic               refresh_en,
    output logic               main_done,
    output logic               snd_done,
    output logic               obj_done,
    output dd2_pkg::rom_word_t rdata
);

    localparam logic [1:0] ST_IDLE = 2'd0;
    localparam logic [1:0] ST_REQ  = 2'd1;
    localparam logic [1:0] ST_WAIT = 2'd2;

    logic [1:0]  state;
    logic [2:0]  owner;         // One-hot {obj, snd, main}
    logic [2:0]  grant;
    logic [21:0] grant_addr;
    logic        rd_end;

    always_comb begin
        grant      = 3'b000;
        grant_addr = obj_addr;
        if (main_req) begin
            grant      = 3'b001;
            grant_addr = main_addr;
        end else if (snd_req) begin
            grant      = 3'b010;
            grant_addr = snd_addr;
        end else if (obj_req) begin
            grant = 3'b100;
        end
    end

    assign rd_end     = (state == ST_WAIT) && data_rdy;
    assign main_done  = rd_end && owner[0];
    assign snd_done   = rd_end && owner[1];
    assign obj_done   = rd_end && owner[2];
    assign rdata      = data_read;
    assign refresh_en = (state == ST_IDLE);

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= ST_IDLE;
            sdram_req <= 1'b0;
            owner     <= 3'b000;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (!downloading && grant != 3'b000) begin
                        owner     <= grant;
                        sdram_req <= 1'b1;
                        state     <= ST_REQ;
                    end
                end
                ST_REQ: begin
                    if (sdram_ack) begin    // Address taken by the controller
                        sdram_req <= 1'b0;
                        state     <= ST_WAIT;
                    end
                end
                ST_WAIT: begin
                    if (data_rdy) state <= ST_IDLE;
                end
                default: state <= ST_IDLE;
            endcase
        end
    end

    // Address is held from grant until the next grant
    always_ff @(posedge clk) begin
        if (state == ST_IDLE && !downloading && grant != 3'b000) begin
            sdram_addr <= grant_addr;
        end
    end

endmodule

// ==== logic/dd2_rom_slot.sv ====
/*
 * Read slot caching one 32-bit SDRAM read. DW must be 8 or 16 and OFFSET even.
 * ok is combinational from cs and addr. A pending fetch always completes, even
 * if addr moved away meanwhile.
 */
`timescale 1ns/1ns

module dd2_rom_slot #(
    parameter int          AW     = 18,
    parameter int          DW     = 8,
    parameter logic [21:0] OFFSET = 22'd0
)(
    input  logic               clk,
    input  logic               rst,
    input  logic               cs,
    input  logic [AW-1:0]      addr,
    input  logic               done,
    input  dd2_pkg::rom_word_t rdata,
    output logic               ok,
    output logic [DW-1:0]      data,
    output logic               req,
    output logic [21:0]        req_addr
);
    import dd2_pkg::*;

    localparam int SW = (DW == 8) ? 2 : 1;  // Address bits that pick inside the word
    localparam int TW = AW - SW;

    rom_word_t     cache;
    logic          valid;
    logic [TW-1:0] tag;
    logic [TW-1:0] pend_tag;    // Tag of the fetch in flight
    logic [TW-1:0] cur_tag;
    logic          hit;
    logic          miss_start;

    assign cur_tag    = addr[AW-1:SW];
    assign hit        = valid && (tag == cur_tag);
    assign ok         = cs && hit;
    assign miss_start = cs && !hit && !req;

    // Tag is the word address with bit 0 dropped, for both widths
    assign req_addr = OFFSET + 22'({pend_tag, 1'b0});

    generate
        if (DW == 8) begin : g_byte
            assign data = cache.b[addr[1:0]];
        end else begin : g_half
            assign data = cache.h[addr[0]];
        end
    endgenerate

    always_ff @(posedge clk) begin
        if (rst) begin
            valid <= 1'b0;
            req   <= 1'b0;
        end else if (done) begin
            valid <= 1'b1;
            req   <= 1'b0;
        end else if (miss_start) begin
            req <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (done) begin
            cache <= rdata;
            tag   <= pend_tag;
        end
        if (miss_start) begin
            pend_tag <= cur_tag;
        end
    end

endmodule

// ==== logic/dd2_dwnld.sv ====
/*
 * Maps loader bytes to SDRAM byte writes. The loader must wait for prog_we to
 * fall before writing again. PROM bytes only produce prom_we, with the low
 * eight address bits on prog_addr.
 */
`timescale 1ns/1ns
`include "dd2_params.svh"

module dd2_dwnld(
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     downloading,
    input  logic [`DD2_SDRAM_AW-1:0] ioctl_addr,
    input  logic [7:0]               ioctl_data,
    input  logic                     ioctl_wr,
    input  logic                     sdram_ack,
    output logic [`DD2_SDRAM_AW-1:0] prog_addr,
    output logic [7:0]               prog_data,
    output logic [1:0]               prog_mask,
    output logic                     prog_we,
    output logic                     prom_we
);

    logic                     wr_valid;
    logic                     is_prom;
    logic [`DD2_SDRAM_AW-1:0] half_offset;  // Byte position inside a ZW/XY half
    logic [`DD2_SDRAM_AW-1:0] wr_addr;
    logic [1:0]               wr_mask;

    assign wr_valid = ioctl_wr && downloading;

    always_comb begin
        is_prom     = 1'b0;
        half_offset = '0;
        // Packed regions by default
        wr_addr     = {1'b0, ioctl_addr[`DD2_SDRAM_AW-1:1]};
        wr_mask     = ioctl_addr[0] ? 2'b01 : 2'b10;
        if (ioctl_addr >= `DD2_PROM_ADDR) begin
            is_prom = 1'b1;
            wr_addr = {14'd0, ioctl_addr[7:0]};
            wr_mask = 2'b11;                    // Nothing goes to SDRAM
        end else if (ioctl_addr >= `DD2_OBJXY_ADDR) begin
            half_offset = ioctl_addr - `DD2_OBJXY_ADDR;
            wr_addr     = `DD2_OBJ_SDRAM + half_offset;
            wr_mask     = 2'b01;                // High byte
        end else if (ioctl_addr >= `DD2_OBJWZ_ADDR) begin
            half_offset = ioctl_addr - `DD2_OBJWZ_ADDR;
            wr_addr     = `DD2_OBJ_SDRAM + half_offset;
            wr_mask     = 2'b10;                // Low byte
        end else if (ioctl_addr >= `DD2_SCRXY_ADDR) begin
            half_offset = ioctl_addr - `DD2_SCRXY_ADDR;
            wr_addr     = `DD2_SCR_SDRAM + half_offset;
            wr_mask     = 2'b01;
        end else if (ioctl_addr >= `DD2_SCRZW_ADDR) begin
            half_offset = ioctl_addr - `DD2_SCRZW_ADDR;
            wr_addr     = `DD2_SCR_SDRAM + half_offset;
            wr_mask     = 2'b10;
        end
    end

    // Write strobes
    always_ff @(posedge clk) begin
        if (rst) begin
            prog_we <= 1'b0;
            prom_we <= 1'b0;
        end else begin
            prom_we <= wr_valid && is_prom;     // Single cycle
            if (wr_valid && !is_prom) begin
                prog_we <= 1'b1;
            end else if (sdram_ack) begin
                prog_we <= 1'b0;
            end
        end
    end

    // Command payload
    always_ff @(posedge clk) begin
        if (wr_valid) begin
            prog_addr <= wr_addr;
            prog_data <= ioctl_data;
            prog_mask <= wr_mask;
        end
    end

endmodule

// ==== logic/dd2_pkg.sv ====
/*
 * One SDRAM read returns two consecutive 16-bit words, word N in the low half.
 * Byte 0 is the low byte of word N.
 */
package dd2_pkg;

    // Same 32 bits, seen by 8-bit or 16-bit slots
    typedef union packed {
        logic [3:0][7:0]  b;    // Byte lanes
        logic [1:0][15:0] h;    // Word N, word N+1
    } rom_word_t;

endpackage

// ==== logic/dd2_params.svh ====
/*
 * ROM map of the loader stream and relocated SDRAM bases. Byte addresses are 22 bits.
 * SDRAM bases are word addresses. Scroll and object halves must stay the same size.
 */
`ifndef DD2_PARAMS_SVH
`define DD2_PARAMS_SVH

// Loader byte addresses
`define DD2_SND_ADDR    22'h02_8000
`define DD2_CHAR_ADDR   22'h08_0000
`define DD2_SCRZW_ADDR  22'h09_0000
`define DD2_SCRXY_ADDR  22'h0B_0000
`define DD2_OBJWZ_ADDR  22'h0D_0000
`define DD2_OBJXY_ADDR  22'h13_0000
`define DD2_PROM_ADDR   22'h19_0000

// Interleaved halves move here, in words
`define DD2_SCR_SDRAM   22'h06_0000
`define DD2_OBJ_SDRAM   22'h08_0000

// Slot address widths
`define DD2_MAIN_AW     18
`define DD2_SND_AW      15
`define DD2_OBJ_AW      19

`define DD2_SDRAM_AW    22

`endif
